// ==== rtl/div_unit_cfg.svh ====
`ifndef DIV_UNIT_CFG_SVH
`define DIV_UNIT_CFG_SVH

// width of the instruction tag that travels with each request
`define DIV_INST_ID_WIDTH 4

// quotient bits produced by the core, one per ITERATE cycle
// 33 because the operands carry an extension bit
`define DIV_ITERATIONS 33

`endif

// ==== rtl/div_unit_pkg.sv ====
`default_nettype none

`include "div_unit_cfg.svh"

package div_unit_pkg;

	typedef logic [31:0] xlen_t; // architectural word
	typedef logic [32:0] opnd_t; // word plus sign/zero extension bit
	typedef logic [4:0] rd_id_t;
	typedef logic [`DIV_INST_ID_WIDTH-1:0] inst_id_t;

	// funct3[1:0] of the M-extension divide group
	// bit 0 set for unsigned, bit 1 set for remainder
	typedef logic [1:0] div_op_t;

	typedef struct packed {
		opnd_t dividend;
		opnd_t divisor;
		logic rem_sel; // return remainder instead of quotient
		logic div_zero;
		logic div_ovf; // signed -2^31 / -1
		rd_id_t rd_id;
		inst_id_t inst_id;
	} div_req_t;

	typedef struct packed {
		xlen_t data;
		rd_id_t rd_id;
		inst_id_t inst_id;
	} div_res_t;

	typedef enum logic [2:0] {
		IDLE,
		ITERATE,
		CHECK,
		FIX,
		DONE
	} div_state_t;

endpackage

`default_nettype wire

// ==== rtl/div_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_decode (
	input wire div_unit_pkg::div_op_t op,
	input wire div_unit_pkg::xlen_t src_a,
	input wire div_unit_pkg::xlen_t src_b,
	input wire div_unit_pkg::rd_id_t rd_id,
	input wire div_unit_pkg::inst_id_t inst_id,
	output div_unit_pkg::div_req_t req
);

	logic is_signed;
	logic is_rem;
	div_unit_pkg::opnd_t dividend;
	div_unit_pkg::opnd_t divisor;
	logic a_is_min; // dividend is -2^31
	logic b_is_neg_one;

	assign is_signed = ~op[0]; // DIV and REM
	assign is_rem = op[1];

	// extension bit is the sign for signed ops, zero otherwise
	assign dividend = {is_signed & src_a[31], src_a};
	assign divisor = {is_signed & src_b[31], src_b};

	assign a_is_min = (src_a == 32'h8000_0000);
	assign b_is_neg_one = (src_b == 32'hffff_ffff);

	always_comb
	begin
		req.dividend = dividend;
		req.divisor = divisor;
		req.rem_sel = is_rem;
		req.div_zero = (src_b == 32'h0000_0000);
		// only the signed forms can overflow
		req.div_ovf = is_signed & a_is_min & b_is_neg_one;
		req.rd_id = rd_id;
		req.inst_id = inst_id;
	end

endmodule

`default_nettype wire

// ==== rtl/div_req_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_req_buffer (
	input wire clk,
	input wire resetn,
	input wire div_unit_pkg::div_req_t wr_data,
	input wire wr_valid,
	output logic wr_ready,
	output div_unit_pkg::div_req_t rd_data,
	output logic rd_valid,
	input wire rd_pop
);

	div_unit_pkg::div_req_t mem [2];
	logic wr_ptr;
	logic rd_ptr;
	logic [1:0] count; // 0, 1 or 2 entries
	logic do_wr;
	logic do_rd;

	assign wr_ready = (count != 2'd2);
	assign rd_valid = (count != 2'd0);
	assign rd_data = mem[rd_ptr]; // head shows without a read request

	assign do_wr = wr_valid & wr_ready;
	assign do_rd = rd_pop & rd_valid;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count <= 2'd0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= ~wr_ptr;
			if (do_rd)
				rd_ptr <= ~rd_ptr;
			case ({do_wr, do_rd})
				2'b10: count <= count + 2'd1;
				2'b01: count <= count - 2'd1;
				default: count <= count; // none, or write and pop together
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

endmodule

`default_nettype wire

// ==== rtl/div_nonrestoring_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "div_unit_cfg.svh"

module div_nonrestoring_core (
	input wire clk,
	input wire resetn,
	input wire div_unit_pkg::div_req_t req,
	input wire req_valid,
	output logic req_pop,
	output div_unit_pkg::opnd_t quotient,
	output div_unit_pkg::opnd_t remainder,
	output logic done_valid,
	input wire done_ready
);

	div_unit_pkg::div_state_t state;
	div_unit_pkg::div_state_t state_nxt;
	logic [$clog2(`DIV_ITERATIONS)-1:0] iter_cnt;
	logic last_iter;

	div_unit_pkg::opnd_t rem_q; // partial remainder R
	div_unit_pkg::opnd_t quo_q; // dividend bits shifting out, quotient bits in
	logic fix_rem;
	logic fix_quo;

	div_unit_pkg::opnd_t dividend;
	div_unit_pkg::opnd_t divisor;
	logic sign_diff;
	logic q_bit;
	div_unit_pkg::opnd_t add_a;
	logic add_sub; // 1 subtracts the divisor
	div_unit_pkg::opnd_t add_res;
	logic need_fix_rem;
	logic need_fix_quo;
	logic exact;

	assign dividend = req.dividend;
	assign divisor = req.divisor;
	assign sign_diff = dividend[32] ^ divisor[32];

	// next quotient bit is set when R and divisor agree in sign
	assign q_bit = ~(rem_q[32] ^ divisor[32]);

	// shared add/subtract for load, iterate and remainder correction
	always_comb
	begin
		add_a = {rem_q[31:0], quo_q[32]}; // {R,Q} shifted left
		add_sub = q_bit;
		if (state == div_unit_pkg::IDLE)
		begin
			add_a = {33{dividend[32]}}; // R starts as dividend sign
			add_sub = ~sign_diff;
		end
		else if (state == div_unit_pkg::FIX)
		begin
			add_a = rem_q;
			add_sub = sign_diff;
		end
	end

	assign add_res = add_a + (divisor ^ {33{add_sub}}) + {32'd0, add_sub};

	assign need_fix_rem = rem_q[32] ^ dividend[32];
	assign need_fix_quo = sign_diff;
	assign last_iter = (iter_cnt == `DIV_ITERATIONS - 1);

	always_comb
	begin
		state_nxt = state;
		case (state)
			div_unit_pkg::IDLE:
				if (req_valid)
					state_nxt = (req.div_zero | req.div_ovf) ? div_unit_pkg::DONE
						: div_unit_pkg::ITERATE;
			div_unit_pkg::ITERATE:
				if (last_iter)
					state_nxt = div_unit_pkg::CHECK;
			div_unit_pkg::CHECK:
				state_nxt = (need_fix_rem | need_fix_quo) ? div_unit_pkg::FIX
					: div_unit_pkg::DONE;
			div_unit_pkg::FIX:
				state_nxt = div_unit_pkg::DONE;
			div_unit_pkg::DONE:
				if (done_ready)
					state_nxt = div_unit_pkg::IDLE;
			default:
				state_nxt = div_unit_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			state <= div_unit_pkg::IDLE;
			iter_cnt <= '0;
			fix_rem <= 1'b0;
			fix_quo <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			if (state == div_unit_pkg::ITERATE)
				iter_cnt <= iter_cnt + 1'b1;
			else
				iter_cnt <= '0;
			if (state == div_unit_pkg::CHECK)
			begin
				fix_rem <= need_fix_rem;
				fix_quo <= need_fix_quo;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		case (state)
			div_unit_pkg::IDLE:
				if (req_valid)
				begin
					if (req.div_zero)
					begin
						rem_q <= dividend;
						quo_q <= '1;
					end
					else if (req.div_ovf)
					begin
						rem_q <= '0;
						quo_q <= dividend; // -2^31 already
					end
					else
					begin
						rem_q <= add_res;
						quo_q <= dividend;
					end
				end
			div_unit_pkg::ITERATE:
			begin
				rem_q <= add_res;
				quo_q <= {quo_q[31:0], q_bit};
			end
			div_unit_pkg::CHECK:
				quo_q <= {quo_q[31:0], q_bit}; // last quotient bit, R unchanged
			div_unit_pkg::FIX:
			begin
				if (fix_rem)
					rem_q <= add_res;
				if (fix_quo)
					quo_q <= quo_q + 33'd1;
			end
			default: ;
		endcase
	end

	// R equal to +-divisor means the division was exact
	assign exact = ~req.div_zero & ~req.div_ovf
		& ((rem_q == divisor) | (rem_q == (~divisor + 33'd1)));

	assign remainder = exact ? '0 : rem_q;
	assign quotient = exact ? (sign_diff ? quo_q - 33'd1 : quo_q + 33'd1) : quo_q;

	assign done_valid = (state == div_unit_pkg::DONE);
	assign req_pop = done_valid & done_ready; // head leaves with its result

endmodule

`default_nettype wire

// ==== rtl/div_result_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_result_stage (
	input wire clk,
	input wire resetn,
	input wire div_unit_pkg::div_req_t req,
	input wire div_unit_pkg::opnd_t quotient,
	input wire div_unit_pkg::opnd_t remainder,
	input wire done_valid,
	output logic done_ready,
	output div_unit_pkg::div_res_t res,
	output logic res_valid,
	input wire res_ready
);

	div_unit_pkg::div_res_t res_nxt;
	logic load;

	assign done_ready = ~res_valid | res_ready; // empty or draining
	assign load = done_valid & done_ready;

	always_comb
	begin
		res_nxt.data = req.rem_sel ? remainder[31:0] : quotient[31:0];
		res_nxt.rd_id = req.rd_id;
		res_nxt.inst_id = req.inst_id;
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			res_valid <= 1'b0;
		else if (done_ready)
			res_valid <= done_valid;
	end

	always_ff @(posedge clk)
	begin
		if (load)
			res <= res_nxt;
	end

endmodule

`default_nettype wire

// ==== rtl/div_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_unit_top (
	input wire clk,
	input wire resetn,
	input wire div_unit_pkg::div_op_t req_op,
	input wire div_unit_pkg::xlen_t req_src_a,
	input wire div_unit_pkg::xlen_t req_src_b,
	input wire div_unit_pkg::rd_id_t req_rd_id,
	input wire div_unit_pkg::inst_id_t req_inst_id,
	input wire req_valid,
	output logic req_ready,
	output div_unit_pkg::div_res_t res,
	output logic res_valid,
	input wire res_ready
);

	div_unit_pkg::div_req_t dec_req;
	div_unit_pkg::div_req_t head_req; // oldest accepted request
	logic head_valid;
	logic head_pop;
	div_unit_pkg::opnd_t core_quotient;
	div_unit_pkg::opnd_t core_remainder;
	logic done_valid;
	logic done_ready;

	div_decode decode0 (
		.op(req_op),
		.src_a(req_src_a),
		.src_b(req_src_b),
		.rd_id(req_rd_id),
		.inst_id(req_inst_id),
		.req(dec_req)
	);

	div_req_buffer buffer0 (
		.clk(clk),
		.resetn(resetn),
		.wr_data(dec_req),
		.wr_valid(req_valid),
		.wr_ready(req_ready),
		.rd_data(head_req),
		.rd_valid(head_valid),
		.rd_pop(head_pop)
	);

	div_nonrestoring_core core0 (
		.clk(clk),
		.resetn(resetn),
		.req(head_req),
		.req_valid(head_valid),
		.req_pop(head_pop),
		.quotient(core_quotient),
		.remainder(core_remainder),
		.done_valid(done_valid),
		.done_ready(done_ready)
	);

	// rd_id and tag come straight from the buffer head
	div_result_stage result0 (
		.clk(clk),
		.resetn(resetn),
		.req(head_req),
		.quotient(core_quotient),
		.remainder(core_remainder),
		.done_valid(done_valid),
		.done_ready(done_ready),
		.res(res),
		.res_valid(res_valid),
		.res_ready(res_ready)
	);

endmodule

`default_nettype wire

// ==== verif/div_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "div_unit_cfg.svh"

module div_unit_tb;

	localparam int WAIT_LIMIT = 4 * `DIV_ITERATIONS; // cycles per handshake wait

	logic clk;
	logic resetn;
	div_unit_pkg::div_op_t req_op;
	div_unit_pkg::xlen_t req_src_a;
	div_unit_pkg::xlen_t req_src_b;
	div_unit_pkg::rd_id_t req_rd_id;
	div_unit_pkg::inst_id_t req_inst_id;
	logic req_valid;
	logic req_ready;
	div_unit_pkg::div_res_t res;
	logic res_valid;
	logic res_ready;

	div_unit_pkg::div_res_t exp_q [$]; // results still owed in issue order
	int unsigned seq;
	integer seed;

	div_unit_top dut0 (
		.clk(clk),
		.resetn(resetn),
		.req_op(req_op),
		.req_src_a(req_src_a),
		.req_src_b(req_src_b),
		.req_rd_id(req_rd_id),
		.req_inst_id(req_inst_id),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.res(res),
		.res_valid(res_valid),
		.res_ready(res_ready)
	);

	always #20 clk = ~clk;

	// RISC-V M rules on plain 32-bit values
	function automatic div_unit_pkg::xlen_t ref_div(input div_unit_pkg::div_op_t op,
		input div_unit_pkg::xlen_t a, input div_unit_pkg::xlen_t b);
		logic is_signed;
		div_unit_pkg::xlen_t q;
		div_unit_pkg::xlen_t r;
		is_signed = ~op[0];
		if (b == 32'd0)
		begin
			q = 32'hffff_ffff;
			r = a;
		end
		else if (is_signed && a == 32'h8000_0000 && b == 32'hffff_ffff)
		begin
			q = 32'h8000_0000;
			r = 32'd0;
		end
		else if (is_signed)
		begin
			q = $signed(a) / $signed(b); // truncates toward zero
			r = $signed(a) % $signed(b);
		end
		else
		begin
			q = a / b;
			r = a % b;
		end
		return op[1] ? r : q;
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_data(input string name, input div_unit_pkg::xlen_t exp,
		input div_unit_pkg::xlen_t act);
		if (act !== exp)
			abort_run($sformatf("ERR time=%0t %s expected=%h actual=%h", $time, name, exp, act));
	endtask

	task automatic check_rd_id(input string name, input div_unit_pkg::rd_id_t exp,
		input div_unit_pkg::rd_id_t act);
		if (act !== exp)
			abort_run($sformatf("ERR time=%0t %s expected=%h actual=%h", $time, name, exp, act));
	endtask

	task automatic check_inst_id(input string name, input div_unit_pkg::inst_id_t exp,
		input div_unit_pkg::inst_id_t act);
		if (act !== exp)
			abort_run($sformatf("ERR time=%0t %s expected=%h actual=%h", $time, name, exp, act));
	endtask

	// called and returns 2 ns after an edge
	task automatic wait_ready(output bit ok);
		int n;
		n = 0;
		while (!req_ready && n < WAIT_LIMIT)
		begin
			@(posedge clk);
			#2;
			n++;
		end
		ok = req_ready;
	endtask

	// transfer happens at the next edge since req_ready was already seen high
	task automatic drive_req(input div_unit_pkg::div_op_t op, input div_unit_pkg::xlen_t a,
		input div_unit_pkg::xlen_t b, input div_unit_pkg::rd_id_t rd,
		input div_unit_pkg::inst_id_t tag);
		div_unit_pkg::div_res_t exp;
		req_op = op;
		req_src_a = a;
		req_src_b = b;
		req_rd_id = rd;
		req_inst_id = tag;
		req_valid = 1'b1;
		@(posedge clk);
		#2;
		req_valid = 1'b0;
		exp.data = ref_div(op, a, b);
		exp.rd_id = rd;
		exp.inst_id = tag;
		exp_q.push_back(exp);
	endtask

	task automatic issue_req(input div_unit_pkg::div_op_t op, input div_unit_pkg::xlen_t a,
		input div_unit_pkg::xlen_t b, input div_unit_pkg::rd_id_t rd,
		input div_unit_pkg::inst_id_t tag);
		bit ok;
		wait_ready(ok);
		if (!ok)
			abort_run("timeout: req_ready never went high for a new request");
		drive_req(op, a, b, rd, tag);
	endtask

	task automatic collect_res();
		int n;
		div_unit_pkg::div_res_t got;
		div_unit_pkg::div_res_t exp;
		n = 0;
		res_ready = 1'b1;
		while (!res_valid && n < WAIT_LIMIT)
		begin
			@(posedge clk);
			#2;
			n++;
		end
		if (!res_valid)
			abort_run("timeout: res_valid never went high for a pending request");
		got = res;
		@(posedge clk);
		#2;
		res_ready = 1'b0;
		exp = exp_q.pop_front();
		check_data("res.data", exp.data, got.data);
		check_rd_id("res.rd_id", exp.rd_id, got.rd_id);
		check_inst_id("res.inst_id", exp.inst_id, got.inst_id);
	endtask

	// every request answered, so res_valid must stay low
	task automatic confirm_no_extra_res();
		int n;
		n = 0;
		while (!res_valid && n < WAIT_LIMIT)
		begin
			@(posedge clk);
			#2;
			n++;
		end
		if (res_valid)
			abort_run("a result arrived with no request pending");
	endtask

	task automatic run_one(input div_unit_pkg::div_op_t op, input div_unit_pkg::xlen_t a,
		input div_unit_pkg::xlen_t b);
		seq++;
		issue_req(op, a, b, div_unit_pkg::rd_id_t'(seq * 7), div_unit_pkg::inst_id_t'(seq));
		collect_res();
	endtask

	// quotient form then remainder form
	task automatic run_pair(input div_unit_pkg::xlen_t a, input div_unit_pkg::xlen_t b,
		input logic is_unsigned);
		run_one({1'b0, is_unsigned}, a, b);
		run_one({1'b1, is_unsigned}, a, b);
	endtask

	task automatic test_signed();
		run_pair(7, -2, 1'b0);
		run_pair(-7, 2, 1'b0);
		run_pair(-7, -2, 1'b0);
		run_pair(7, 2, 1'b0);
		run_pair(100, -7, 1'b0);
		run_pair(-1, 3, 1'b0);
	endtask

	task automatic test_unsigned();
		run_pair(32'hffff_ffff, 3, 1'b1);
		run_pair(32'h8000_0000, 7, 1'b1);
		run_pair(32'hfedc_ba98, 32'h8000_0001, 1'b1);
		run_pair(5, 32'hffff_fffe, 1'b1);
		run_pair(32'h9000_0000, 32'h9000_0000, 1'b1);
	endtask

	task automatic test_special();
		run_pair(32'h1234_5678, 0, 1'b0);
		run_pair(32'h1234_5678, 0, 1'b1);
		run_pair(32'hffff_fff9, 0, 1'b0);
		run_pair(32'h8000_0000, 0, 1'b1);
		run_pair(32'h8000_0000, 32'hffff_ffff, 1'b0); // signed overflow
		run_pair(32'h8000_0000, 32'hffff_ffff, 1'b1); // not an overflow unsigned
	endtask

	task automatic test_exact();
		run_pair(-12, 3, 1'b0);
		run_pair(12, -4, 1'b0);
		run_pair(-8, -8, 1'b0);
		run_pair(-12, -3, 1'b0);
		run_pair(32'hffff_fffc, 4, 1'b1);
	endtask

	task automatic test_backpressure();
		bit ok;
		int accepted;
		accepted = 0;
		res_ready = 1'b0;
		for (int i = 0; i < 6; i++)
		begin
			wait_ready(ok);
			if (!ok)
				break; // req_ready stayed low
			drive_req(i[1:0], 1000 + i * 37, i + 3, 5'(20 + i), 4'(9 + i));
			accepted++;
		end
		// output register plus two buffer entries
		if (accepted != 3)
			abort_run($sformatf("back-pressure: %0d requests accepted instead of 3", accepted));
		while (exp_q.size() != 0)
			collect_res();
		confirm_no_extra_res();
	endtask

	task automatic test_random();
		div_unit_pkg::xlen_t a;
		div_unit_pkg::xlen_t b;
		for (int i = 0; i < 40; i++)
		begin
			a = $random(seed);
			b = $random(seed);
			if (b[3:0] == 4'd0)
				b = b >> 28; // small divisors and now and then zero
			issue_req(2'($random(seed)), a, b, 5'($random(seed)), 4'($random(seed)));
			collect_res();
		end
	endtask

	initial
	begin
		clk = 1'b0;
		resetn = 1'b0;
		req_op = '0;
		req_src_a = '0;
		req_src_b = '0;
		req_rd_id = '0;
		req_inst_id = '0;
		req_valid = 1'b0;
		res_ready = 1'b0;
		seq = 0;
		seed = 53;
		repeat (16) @(posedge clk);
		#2;
		resetn = 1'b1;
		@(posedge clk);
		#2;
		test_signed();
		test_unsigned();
		test_special();
		test_exact();
		test_backpressure();
		test_random();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+rtl
rtl/div_unit_pkg.sv
rtl/div_decode.sv
rtl/div_req_buffer.sv
rtl/div_nonrestoring_core.sv
rtl/div_result_stage.sv
rtl/div_unit_top.sv
verif/div_unit_tb.sv

// ==== Bender.yml ====
package:
  name: div_unit

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/div_unit_pkg.sv
      - rtl/div_decode.sv
      - rtl/div_req_buffer.sv
      - rtl/div_nonrestoring_core.sv
      - rtl/div_result_stage.sv
      - rtl/div_unit_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verif/div_unit_tb.sv
